// ==== hdl/sprite_cfg.svh ====
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

// register file
`define NUM_REGS 32
`define REG_W 32

// program memory
`define PROG_DEPTH 64
`define INSTR_W 36
`define PC_W 7 // one bit past the rom range so running off the end is visible

// sprite table geometry
`define NUM_SPRITES 16
`define SPRITE_FIELDS 8
`define FIELD_W 16

// display link starts with this many credits
`define SCAN_CREDITS 2

`endif

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

  // one 36-bit word, read in two layouts depending on opcode
  typedef union packed {
    struct packed {
      logic [2:0] fsel;   // sprite field select
      logic       ext;    // sprite-class extension bit
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [2:0]  fsel;
      logic        ext;
      logic [19:0] imm20; // LI / SPLI constant, JMP target
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } instr_t;

  // {ext, opcode}
  typedef enum logic [7:0] {
    OP_HALT   = 8'h00,
    OP_REGIMM = 8'h13,
    OP_REG    = 8'h33,
    OP_LI     = 8'h37,
    OP_JMP    = 8'h61,
    OP_BRANCH = 8'h63,
    OP_SPIMM  = 8'h93,
    OP_SPLI   = 8'hb7,
    OP_LISP   = 8'hbf
  } opcode_t;

  typedef enum logic [3:0] {
    PASS, ADD, SUBF, SLL, SRL, ABS, BEQ, BNE, JUMP, NONE
  } alu_op_t;

  localparam logic [2:0] F3_ADDI   = 3'd0;
  localparam logic [2:0] F3_SPADDI = 3'd0;
  localparam logic [2:0] F3_SPSUBI = 3'd1; // floored at zero
  localparam logic [2:0] F3_BEQ    = 3'd0;
  localparam logic [2:0] F3_BNE    = 3'd1;

  localparam logic [6:0] F7_ADD = 7'd0;
  localparam logic [6:0] F7_SUB = 7'd1; // floored at zero
  localparam logic [6:0] F7_SLL = 7'd2;
  localparam logic [6:0] F7_SRL = 7'd4;
  localparam logic [6:0] F7_ABS = 7'd5;

endpackage

// ==== hdl/sprite_pkg.sv ====
`include "sprite_cfg.svh"

package sprite_pkg;

  typedef logic [$clog2(`SPRITE_FIELDS)-1:0] field_idx_t;
  typedef logic [$clog2(`NUM_SPRITES)-1:0] slot_t;
  typedef logic [`FIELD_W-1:0] field_t;

  // field layout of one slot
  localparam field_idx_t FIELD_TYPE  = field_idx_t'(0); // nonzero = live
  localparam field_idx_t FIELD_X     = field_idx_t'(1);
  localparam field_idx_t FIELD_Y     = field_idx_t'(2);
  localparam field_idx_t FIELD_FRAME = field_idx_t'(3);

endpackage

// ==== hdl/program_rom.sv ====
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module program_rom
  import isa_pkg::*;
(
  input  logic                            pixel_clk_in,
  input  logic                            load_we,
  input  logic [$clog2(`PROG_DEPTH)-1:0]  load_addr,
  input  logic [`INSTR_W-1:0]             load_data,
  input  logic [$clog2(`PROG_DEPTH)-1:0]  rd_addr,
  output instr_t                          rd_data
);

  logic [`INSTR_W-1:0] mem [`PROG_DEPTH];

  // single clock, write port for loading and one registered read
  always_ff @(posedge pixel_clk_in) begin
    if (load_we) begin
      mem[load_addr] <= load_data;
    end
    rd_data <= instr_t'(mem[rd_addr]); // valid one cycle after address
  end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module decode_stage
  import isa_pkg::*;
  import sprite_pkg::*;
(
  input  logic                           pixel_clk_in,
  input  logic                           rst_in,
  input  logic                           go,
  input  instr_t                         instr,
  output logic [$clog2(`PROG_DEPTH)-1:0] rom_addr,
  output logic [$clog2(`NUM_REGS)-1:0]   rs1_addr,
  output logic [$clog2(`NUM_REGS)-1:0]   rs2_addr,
  input  logic [`REG_W-1:0]              rs1_val,
  input  logic [`REG_W-1:0]              rs2_val,
  output slot_t                          sp_slot,
  output field_idx_t                     sp_field,
  input  field_t                         sp_val,
  input  logic                           branch_taken,
  input  logic [`PC_W-1:0]               branch_target,
  output alu_op_t                        op,
  output logic [`REG_W-1:0]              a,
  output logic [`REG_W-1:0]              b,
  output logic [$clog2(`NUM_REGS)-1:0]   dest_reg,
  output slot_t                          dest_slot,
  output field_idx_t                     dest_field,
  output logic                           to_sprite,
  output logic                           writes,
  output logic                           halted
);

  localparam logic [1:0] PH_FETCH  = 2'd0;
  localparam logic [1:0] PH_DECODE = 2'd1;
  localparam logic [1:0] PH_EXEC   = 2'd2;
  localparam logic [1:0] PH_RESULT = 2'd3;

  logic [1:0]                     phase;
  logic [`PC_W-1:0]               pc;
  logic                           stop_q;  // halt once this instruction retires
  opcode_t                        opc;
  logic [`REG_W-1:0]              imm20;
  logic [`REG_W-1:0]              imm12;
  logic [`PC_W-1:0]               tgt;
  alu_op_t                        nxt_op;
  logic [`REG_W-1:0]              nxt_a;
  logic [`REG_W-1:0]              nxt_b;
  logic [$clog2(`NUM_REGS)-1:0]   nxt_reg;
  slot_t                          nxt_slot;
  logic                           nxt_sprite;
  logic                           nxt_writes;
  logic                           nxt_stop;

  assign opc   = opcode_t'({instr.r.ext, instr.r.opcode});
  assign imm20 = `REG_W'(instr.u.imm20);                     // zero extended
  assign imm12 = `REG_W'({instr.r.funct7, instr.r.rs2});

  assign rom_addr = pc[$clog2(`PROG_DEPTH)-1:0];
  assign rs1_addr = instr.r.rs1;
  // sprite writes name their slot through register rd
  assign rs2_addr = (opc == OP_SPLI || opc == OP_SPIMM) ? instr.r.rd : instr.r.rs2;
  assign sp_slot  = slot_t'(rs1_val); // LISP source slot
  assign sp_field = instr.r.fsel;

  always_comb begin
    nxt_op     = NONE;
    nxt_a      = rs1_val;
    nxt_b      = rs2_val;
    nxt_reg    = instr.r.rd;
    nxt_slot   = slot_t'(rs2_val);
    nxt_sprite = 1'b0;
    nxt_writes = 1'b0;
    nxt_stop   = 1'b0;
    tgt        = '0;
    case (opc)
      OP_LI: begin
        nxt_op     = PASS;
        nxt_a      = imm20;
        nxt_writes = 1'b1;
      end
      OP_REGIMM: begin
        nxt_op     = (instr.r.funct3 == F3_ADDI) ? ADD : NONE;
        nxt_b      = imm12;
        nxt_writes = (instr.r.funct3 == F3_ADDI);
      end
      OP_REG: begin
        nxt_writes = 1'b1;
        case (instr.r.funct7)
          F7_ADD:  nxt_op = ADD;
          F7_SUB:  nxt_op = SUBF;
          F7_SLL:  nxt_op = SLL;
          F7_SRL:  nxt_op = SRL;
          F7_ABS:  nxt_op = ABS;
          default: nxt_writes = 1'b0; // unknown funct7 acts as nop
        endcase
      end
      OP_SPLI: begin
        nxt_op     = PASS;
        nxt_a      = imm20;
        nxt_sprite = 1'b1;
        nxt_writes = 1'b1;
      end
      OP_SPIMM: begin
        nxt_b      = imm12;
        nxt_sprite = 1'b1;
        nxt_writes = 1'b1;
        case (instr.r.funct3)
          F3_SPADDI: nxt_op = ADD;
          F3_SPSUBI: nxt_op = SUBF;
          default:   nxt_writes = 1'b0;
        endcase
      end
      OP_LISP: begin
        nxt_op     = PASS;
        nxt_a      = `REG_W'(sp_val);
        nxt_writes = 1'b1;
      end
      OP_BRANCH: begin
        nxt_op = (instr.r.funct3 == F3_BEQ) ? BEQ :
                 (instr.r.funct3 == F3_BNE) ? BNE : NONE;
        tgt    = `PC_W'({instr.r.funct7, instr.r.rd});
      end
      OP_JMP: begin
        nxt_op = JUMP;
        tgt    = `PC_W'({instr.u.imm20, instr.u.rd});
      end
      OP_HALT: nxt_stop = 1'b1;
      default: ; // undefined opcode is a nop
    endcase
    // branches write nothing so the dest fields carry the target
    if (nxt_op == BEQ || nxt_op == BNE || nxt_op == JUMP) begin
      nxt_reg  = tgt[$clog2(`NUM_REGS)-1:0];
      nxt_slot = slot_t'(tgt >> $clog2(`NUM_REGS));
    end
    // ran off the end of program memory
    if (pc >= `PC_W'(`PROG_DEPTH)) begin
      nxt_op     = NONE;
      nxt_writes = 1'b0;
      nxt_stop   = 1'b1;
    end
  end

  // sequencer and pc
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      phase     <= PH_FETCH;
      pc        <= '0;
      halted    <= 1'b1;
      stop_q    <= 1'b0;
      op        <= NONE;
      to_sprite <= 1'b0;
      writes    <= 1'b0;
    end else if (halted) begin
      if (go) begin // restart from address 0
        halted <= 1'b0;
        pc     <= '0;
        phase  <= PH_FETCH;
      end
    end else begin
      phase <= phase + 2'd1;
      case (phase)
        PH_DECODE: begin
          op        <= nxt_op;
          to_sprite <= nxt_sprite;
          writes    <= nxt_writes;
          stop_q    <= nxt_stop;
        end
        PH_EXEC: begin // one-shot so execute sees a single op
          op        <= NONE;
          to_sprite <= 1'b0;
          writes    <= 1'b0;
        end
        PH_RESULT: begin
          pc     <= branch_taken ? branch_target : pc + 1'b1;
          halted <= stop_q;
        end
        default: ; // fetch waits on the rom
      endcase
    end
  end

  // operand payload
  always_ff @(posedge pixel_clk_in) begin
    if (!halted && phase == PH_DECODE) begin
      a          <= nxt_a;
      b          <= nxt_b;
      dest_reg   <= nxt_reg;
      dest_slot  <= nxt_slot;
      dest_field <= instr.r.fsel;
    end
  end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module execute_stage
  import isa_pkg::*;
  import sprite_pkg::*;
(
  input  logic                         pixel_clk_in,
  input  logic                         rst_in,
  input  alu_op_t                      op,
  input  logic [`REG_W-1:0]            a,
  input  logic [`REG_W-1:0]            b,
  input  logic [$clog2(`NUM_REGS)-1:0] dest_reg,
  input  slot_t                        dest_slot,
  input  field_idx_t                   dest_field,
  input  logic                         to_sprite,
  input  logic                         writes,
  output logic [`REG_W-1:0]            res,
  output logic [$clog2(`NUM_REGS)-1:0] wb_reg,
  output slot_t                        wb_slot,
  output field_idx_t                   wb_field,
  output logic                         wb_sprite,
  output logic                         wb_en,
  output logic                         branch_taken,
  output logic [`PC_W-1:0]             branch_target
);

  logic [`REG_W-1:0] alu_res;
  logic              taken;

  always_comb begin
    alu_res = a;
    case (op)
      ADD:     alu_res = a + b;
      SUBF:    alu_res = (a >= b) ? a - b : '0; // floors at 0
      SLL:     alu_res = a << b[4:0];
      SRL:     alu_res = a >> b[4:0];
      ABS:     alu_res = (a > b) ? a - b : b - a;
      default: alu_res = a; // PASS and the rest
    endcase
  end

  assign taken = (op == BEQ && a == b) || (op == BNE && a != b) || op == JUMP;

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      wb_en        <= 1'b0;
      wb_sprite    <= 1'b0;
      branch_taken <= 1'b0;
    end else begin
      wb_en        <= writes;
      wb_sprite    <= to_sprite;
      branch_taken <= taken;
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    res           <= alu_res;
    wb_reg        <= dest_reg;
    wb_slot       <= dest_slot;
    wb_field      <= dest_field;
    branch_target <= `PC_W'({dest_slot, dest_reg}); // target packed in dest fields
  end

endmodule

// ==== hdl/result_stage.sv ====
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module result_stage
  import sprite_pkg::*;
(
  input  logic                         pixel_clk_in,
  input  logic                         rst_in,
  input  logic [$clog2(`NUM_REGS)-1:0] rs1_addr,
  input  logic [$clog2(`NUM_REGS)-1:0] rs2_addr,
  output logic [`REG_W-1:0]            rs1_val,
  output logic [`REG_W-1:0]            rs2_val,
  input  logic [`REG_W-1:0]            res,
  input  logic [$clog2(`NUM_REGS)-1:0] wb_reg,
  input  slot_t                        wb_slot,
  input  field_idx_t                   wb_field,
  input  logic                         wb_sprite,
  input  logic                         wb_en,
  output logic                         sp_we,
  output slot_t                        sp_wslot,
  output field_idx_t                   sp_wfield,
  output field_t                       sp_wdata
);

  logic [`REG_W-1:0] regs [`NUM_REGS];

  // x0 never written so it reads as zero
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && !wb_sprite && wb_reg != '0) begin
      regs[wb_reg] <= res;
    end
  end

  // async read ports for decode
  assign rs1_val = regs[rs1_addr];
  assign rs2_val = regs[rs2_addr];

  // sprite results go out as a one-cycle strobe
  assign sp_we     = wb_en & wb_sprite;
  assign sp_wslot  = wb_slot;
  assign sp_wfield = wb_field;
  assign sp_wdata  = field_t'(res); // upper bits dropped

endmodule

// ==== hdl/sprite_table.sv ====
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_table
  import sprite_pkg::*;
(
  input  logic       pixel_clk_in,
  input  logic       rst_in,
  input  logic       sp_we,
  input  slot_t      sp_wslot,
  input  field_idx_t sp_wfield,
  input  field_t     sp_wdata,
  input  slot_t      sp_slot,
  input  field_idx_t sp_field,
  output field_t     sp_val,
  input  logic       new_frame,
  input  logic       sprite_credit,
  output field_t     x,
  output field_t     y,
  output field_t     frame,
  output logic       sprite_valid
);

  localparam int CW = $clog2(`SCAN_CREDITS + 1);

  field_t        fields [`NUM_SPRITES * `SPRITE_FIELDS]; // indexed {slot, field}
  slot_t         scan_ptr;
  logic          scan_on;
  logic [CW-1:0] credits;
  logic          live;
  logic          emit;
  logic          last;

  // storage, only type fields need clearing
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < `NUM_SPRITES; i++) begin
        fields[{slot_t'(i), FIELD_TYPE}] <= '0;
      end
    end else if (sp_we) begin
      fields[{sp_wslot, sp_wfield}] <= sp_wdata;
    end
  end

  assign sp_val = fields[{sp_slot, sp_field}]; // LISP operand

  assign live = fields[{scan_ptr, FIELD_TYPE}] != '0;
  assign emit = scan_on && live && credits != '0;
  assign last = scan_ptr == slot_t'(`NUM_SPRITES - 1);

  // scanner and credit counter
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      scan_on      <= 1'b0;
      scan_ptr     <= '0;
      credits      <= CW'(`SCAN_CREDITS);
      sprite_valid <= 1'b0;
    end else begin
      sprite_valid <= emit;
      credits      <= credits - CW'(emit) + CW'(sprite_credit);
      if (new_frame) begin
        scan_ptr <= '0;
        scan_on  <= 1'b1;
      end else if (scan_on && (emit || !live)) begin // stall on live slot w/o credit
        scan_ptr <= scan_ptr + 1'b1;
        if (last) begin
          scan_on <= 1'b0; // idle till next frame
        end
      end
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (emit) begin
      x     <= fields[{scan_ptr, FIELD_X}];
      y     <= fields[{scan_ptr, FIELD_Y}];
      frame <= fields[{scan_ptr, FIELD_FRAME}];
    end
  end

endmodule

// ==== hdl/sprite_core.sv ====
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_core
  import isa_pkg::*;
  import sprite_pkg::*;
(
  input  logic                           pixel_clk_in,
  input  logic                           rst_in,
  input  logic                           load_we,
  input  logic [$clog2(`PROG_DEPTH)-1:0] load_addr,
  input  logic [`INSTR_W-1:0]            load_data,
  input  logic                           go,
  input  logic                           new_frame,
  input  logic                           sprite_credit,
  output logic                           halted,
  output field_t                         x,
  output field_t                         y,
  output field_t                         frame,
  output logic                           sprite_valid
);

  instr_t                         instr;
  logic [$clog2(`PROG_DEPTH)-1:0] rom_addr;
  logic [$clog2(`NUM_REGS)-1:0]   rs1_addr, rs2_addr;
  logic [`REG_W-1:0]              rs1_val, rs2_val;
  slot_t                          sp_slot;
  field_idx_t                     sp_field;
  field_t                         sp_val;
  logic                           branch_taken;
  logic [`PC_W-1:0]               branch_target;
  alu_op_t                        op;
  logic [`REG_W-1:0]              a, b, res;
  logic [$clog2(`NUM_REGS)-1:0]   dest_reg, wb_reg;
  slot_t                          dest_slot, wb_slot, sp_wslot;
  field_idx_t                     dest_field, wb_field, sp_wfield;
  logic                           to_sprite, writes, wb_sprite, wb_en, sp_we;
  field_t                         sp_wdata;

  program_rom rom (
    .pixel_clk_in, .load_we(load_we & halted), // loads only while stopped
    .load_addr, .load_data, .rd_addr(rom_addr), .rd_data(instr)
  );

  decode_stage dec (
    .pixel_clk_in, .rst_in, .go, .instr, .rom_addr,
    .rs1_addr, .rs2_addr, .rs1_val, .rs2_val,
    .sp_slot, .sp_field, .sp_val, .branch_taken, .branch_target,
    .op, .a, .b, .dest_reg, .dest_slot, .dest_field,
    .to_sprite, .writes, .halted
  );

  execute_stage exe (
    .pixel_clk_in, .rst_in, .op, .a, .b, .dest_reg, .dest_slot, .dest_field,
    .to_sprite, .writes, .res, .wb_reg, .wb_slot, .wb_field, .wb_sprite, .wb_en,
    .branch_taken, .branch_target
  );

  result_stage rsl (
    .pixel_clk_in, .rst_in, .rs1_addr, .rs2_addr, .rs1_val, .rs2_val,
    .res, .wb_reg, .wb_slot, .wb_field, .wb_sprite, .wb_en,
    .sp_we, .sp_wslot, .sp_wfield, .sp_wdata
  );

  sprite_table spt (
    .pixel_clk_in, .rst_in, .sp_we, .sp_wslot, .sp_wfield, .sp_wdata,
    .sp_slot, .sp_field, .sp_val, .new_frame, .sprite_credit,
    .x, .y, .frame, .sprite_valid
  );

endmodule

// ==== tests/tb_sprite_core.sv ====
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module tb_sprite_core
  import sprite_pkg::*;
();

  localparam int AW           = $clog2(`PROG_DEPTH);
  localparam int STIM_DEPTH   = 256;
  localparam int WATCH_CYCLES = 40; // longer than a full 16-slot scan

  logic                pixel_clk_in = 1'b0;
  logic                rst_in;
  logic                load_we;
  logic [AW-1:0]       load_addr;
  logic [`INSTR_W-1:0] load_data;
  logic                go;
  logic                new_frame;
  logic                sprite_credit;
  logic                halted;
  field_t              x;
  field_t              y;
  field_t              frame;
  logic                sprite_valid;

  logic [`INSTR_W-1:0] stim [STIM_DEPTH]; // count, program, count, triples
  field_t              seen_x [$];
  field_t              seen_y [$];
  field_t              seen_f [$];
  int                  n_prog;
  int                  n_emit;
  int                  first_burst;
  int                  mismatches;
  int                  failures;
  int unsigned         rng_seed;
  int unsigned         delay;

  sprite_core uut (
    .pixel_clk_in, .rst_in, .load_we, .load_addr, .load_data,
    .go, .new_frame, .sprite_credit, .halted,
    .x, .y, .frame, .sprite_valid
  );

  always #20 pixel_clk_in = ~pixel_clk_in; // 40 ns period

  // emission log for the final compare
  always @(negedge pixel_clk_in) begin
    if (rst_in === 1'b0 && sprite_valid === 1'b1) begin
      seen_x.push_back(x);
      seen_y.push_back(y);
      seen_f.push_back(frame);
    end else if (rst_in === 1'b0 && sprite_valid !== 1'b0) begin
      failures++; // unknown valid, e.g. uncleared type field
      $display("sprite_valid is unknown at %0t ns", $time);
    end
  end

  task automatic check_field(input string name, input field_t got, input field_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s expected %b, got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_count(input string when, input int got, input int exp);
    if (got != exp) begin
      failures++;
      $display("Wrong number of sprite emissions %s: expected %0d, saw %0d", when, exp, got);
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < n_prog; i++) begin
      @(posedge pixel_clk_in);
      load_we   <= 1'b1;
      load_addr <= AW'(i);
      load_data <= stim[1 + i]; // word 0 of the file is the count
    end
    @(posedge pixel_clk_in);
    load_we <= 1'b0;
  endtask

  task automatic start_core();
    @(posedge pixel_clk_in);
    go <= 1'b1;
    @(posedge pixel_clk_in);
    go <= 1'b0; // one-cycle go pulse
  endtask

  task automatic start_frame();
    @(posedge pixel_clk_in);
    new_frame <= 1'b1;
    @(posedge pixel_clk_in);
    new_frame <= 1'b0;
  endtask

  task automatic return_credit();
    @(posedge pixel_clk_in);
    sprite_credit <= 1'b1;
    @(posedge pixel_clk_in);
    sprite_credit <= 1'b0;
  endtask

  task automatic watch(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge pixel_clk_in);
    end
  endtask

  task automatic wait_halted(input logic level, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge pixel_clk_in);
      n++;
    end while (halted !== level && n < limit);
    if (halted !== level) begin
      failures++;
      $display("Timeout: halted did not reach %b within %0d cycles", level, limit);
    end
  endtask

  // block until the log holds count emissions
  task automatic wait_emissions(input int count, input int limit);
    int n;
    n = 0;
    while (seen_x.size() < count && n < limit) begin
      @(posedge pixel_clk_in);
      n++;
    end
    if (seen_x.size() < count) begin
      failures++;
      $display("Timeout: emission %0d did not arrive within %0d cycles", count, limit);
    end
  endtask

  task automatic check_emissions();
    int base;
    base = n_prog + 2; // first triple after the emission count
    check_count("after all credits returned", seen_x.size(), n_emit);
    for (int i = 0; i < n_emit && i < seen_x.size(); i++) begin
      check_field($sformatf("x[%0d]", i), seen_x[i], field_t'(stim[base + 3 * i]));
      check_field($sformatf("y[%0d]", i), seen_y[i], field_t'(stim[base + 3 * i + 1]));
      check_field($sformatf("frame[%0d]", i), seen_f[i], field_t'(stim[base + 3 * i + 2]));
    end
  endtask

  initial begin
    rst_in        = 1'b1;
    load_we       = 1'b0;
    load_addr     = '0;
    load_data     = '0;
    go            = 1'b0;
    new_frame     = 1'b0;
    sprite_credit = 1'b0;
    mismatches    = 0;
    failures      = 0;
    rng_seed      = 32'h1317_34ad;
    delay         = $urandom(rng_seed); // seeds the generator once
    $readmemh("tests/program_stimulus.mem", stim);
    n_prog = int'(stim[0]);
    n_emit = int'(stim[n_prog + 1]);

    repeat (3) @(posedge pixel_clk_in);
    rst_in <= 1'b0;

    // reset state and a scan over the empty table
    @(negedge pixel_clk_in);
    check_bit("halted", halted, 1'b1);
    check_bit("sprite_valid", sprite_valid, 1'b0);
    start_frame();
    watch(WATCH_CYCLES);
    check_count("from an empty table", seen_x.size(), 0);

    load_program();
    start_core();
    wait_halted(1'b0, 8);
    wait_halted(1'b1, 2000);

    // credits withheld so the scanner stalls after the initial ones
    first_burst = (n_emit < `SCAN_CREDITS) ? n_emit : `SCAN_CREDITS;
    start_frame();
    watch(WATCH_CYCLES);
    check_count("with credits withheld", seen_x.size(), first_burst);

    // one credit back per emission received after a random gap
    for (int i = 0; i < n_emit; i++) begin
      wait_emissions(i + 1, 100);
      delay = $urandom % 6 + 1;
      repeat (delay) @(posedge pixel_clk_in);
      return_credit();
    end
    watch(WATCH_CYCLES); // any duplicate shows up here
    check_emissions();

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== tests/program_stimulus.mem ====
// word count, then 36-bit program words {fsel, ext, funct7/imm, rs2, rs1, funct3, rd, opcode}
// then emission count, then one x y frame triple per line in slot order
1f
0000000b7 // 00 li r1, 0
000003137 // 01 li r2, 3
00000a1b7 // 02 li r3, 10
1000010b7 // 03 spli [r1].type, 1
300018093 // 04 spaddi [r1].x, r3, 0
500518093 // 05 spaddi [r1].y, r3, 5
700208093 // 06 spaddi [r1].frame, r1, 2
000718193 // 07 addi r3, r3, 7
000108093 // 08 addi r1, r1, 1
0002091e3 // 09 bne r1, r2, 3
000064237 // 10 li r4, 100
0000022b7 // 11 li r5, 2
004520333 // 12 sll r6, r4, r5
0004303b3 // 13 add r7, r6, r4
008538433 // 14 srl r8, r7, r5
0000014b7 // 15 li r9, 1
700040493 // 16 spaddi [r9].frame, r8, 0
1000010b7 // 17 spli [r1].type, 1
300929093 // 18 spsubi [r1].x, r5, 9
502821093 // 19 spsubi [r1].y, r4, 40
30004853f // 20 lisp r10, [r9].x
5000005bf // 21 lisp r11, [r0].y
00aa58633 // 22 abs r12, r11, r10
700060093 // 23 spaddi [r1].frame, r12, 0
0000046b7 // 24 li r13, 4
000000de1 // 25 jmp 27
1000016b7 // 26 spli [r13].type, 1
000005737 // 27 li r14, 5
000528f63 // 28 beq r5, r5, 30
100001737 // 29 spli [r14].type, 1
000000000 // 30 halt
4
000a 000f 0002 // slot 0
0011 0016 007d // slot 1
0018 001d 0004 // slot 2
0000 003c 0002 // slot 3

// ==== tb.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/sprite_pkg.sv
hdl/program_rom.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/sprite_table.sv
hdl/sprite_core.sv
tests/tb_sprite_core.sv

// ==== Bender.yml ====
package:
  name: sprite_core

export_include_dirs:
  - hdl

sources:
  - hdl/isa_pkg.sv
  - hdl/sprite_pkg.sv
  - hdl/program_rom.sv
  - hdl/decode_stage.sv
  - hdl/execute_stage.sv
  - hdl/result_stage.sv
  - hdl/sprite_table.sv
  - hdl/sprite_core.sv
  - target: test
    files:
      - tests/tb_sprite_core.sv
